/* hw/fp_noncomp_unit.sv */
// FP32 only; result appears one cycle after the accepting edge (second edge counting it), flush drops all
`timescale 1ns/1ps
`default_nettype none

module fp_noncomp_unit (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      in_valid_i,
    input  fpu_wrap_pkg::fp_op_e      fp_op_i,
    input  fpu_wrap_pkg::sub_op_t     sub_op_i,
    input  fpu_wrap_pkg::fp_word_t    operand_a_i,
    input  fpu_wrap_pkg::fp_word_t    operand_b_i,
    input  fpu_wrap_pkg::trans_id_t   tag_i,
    output logic                      in_ready_o,
    output logic                      out_valid_o,
    output fpu_wrap_pkg::fp_word_t    result_o,
    output fpu_wrap_pkg::fp_status_t  status_o,
    output fpu_wrap_pkg::trans_id_t   tag_o,
    input  logic                      out_ready_i
);

    // One-hot class of an FP32 word
    function automatic logic [9:0] class_mask(fpu_wrap_pkg::fp_word_t x);
        logic       exp_zero;
        logic       exp_ones;
        logic       man_zero;
        logic [9:0] m;
        exp_zero = (x[30:23] == 8'h00);
        exp_ones = (x[30:23] == 8'hFF);
        man_zero = (x[22:0] == '0);
        m        = '0;
        if (exp_ones && !man_zero) begin
            m[x[22] ? fpu_wrap_pkg::CLASS_QNAN : fpu_wrap_pkg::CLASS_SNAN] = 1'b1;
        end else if (exp_ones) begin
            m[x[31] ? fpu_wrap_pkg::CLASS_NEG_INF : fpu_wrap_pkg::CLASS_POS_INF] = 1'b1;
        end else if (exp_zero && man_zero) begin
            m[x[31] ? fpu_wrap_pkg::CLASS_NEG_ZERO : fpu_wrap_pkg::CLASS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            m[x[31] ? fpu_wrap_pkg::CLASS_NEG_SUB : fpu_wrap_pkg::CLASS_POS_SUB] = 1'b1;
        end else begin
            m[x[31] ? fpu_wrap_pkg::CLASS_NEG_NORM : fpu_wrap_pkg::CLASS_POS_NORM] = 1'b1;
        end
        return m;
    endfunction

    // Numeric order on non-NaN values, -0 below +0
    function automatic logic fp_less(fpu_wrap_pkg::fp_word_t x, fpu_wrap_pkg::fp_word_t y);
        if (x[31] != y[31]) begin
            return x[31];                 // Negative is the smaller one
        end
        return x[31] ? (x[30:0] > y[30:0]) : (x[30:0] < y[30:0]);
    endfunction

    // Stage 1 holds the request
    logic                      s1_valid_q;
    fpu_wrap_pkg::fp_op_e      s1_op_q;
    fpu_wrap_pkg::sub_op_t     s1_sub_q;
    fpu_wrap_pkg::fp_word_t    s1_a_q, s1_b_q;
    fpu_wrap_pkg::trans_id_t   s1_tag_q;
    // Stage 2 holds the answer
    logic                      s2_valid_q;
    fpu_wrap_pkg::fp_word_t    s2_result_q;
    fpu_wrap_pkg::fp_status_t  s2_status_q;
    fpu_wrap_pkg::trans_id_t   s2_tag_q;

    logic                      s2_ready;     // Stage 2 can take a new item
    logic [9:0]                cls_a, cls_b;
    logic                      a_nan, b_nan, a_snan, b_snan, any_nan, any_snan;
    logic                      both_zero, a_lt_b, a_eq_b;
    fpu_wrap_pkg::fp_word_t    result_d;
    fpu_wrap_pkg::fp_status_t  status_d;

    assign s2_ready   = !s2_valid_q || out_ready_i;
    assign in_ready_o = !s1_valid_q || s2_ready;   // Empty or moving on

    // ------------------------------------------------------------------------
    // Operation logic between the stages
    // ------------------------------------------------------------------------
    assign cls_a     = class_mask(s1_a_q);
    assign cls_b     = class_mask(s1_b_q);
    assign a_snan    = cls_a[fpu_wrap_pkg::CLASS_SNAN];
    assign b_snan    = cls_b[fpu_wrap_pkg::CLASS_SNAN];
    assign a_nan     = a_snan || cls_a[fpu_wrap_pkg::CLASS_QNAN];
    assign b_nan     = b_snan || cls_b[fpu_wrap_pkg::CLASS_QNAN];
    assign any_nan   = a_nan || b_nan;
    assign any_snan  = a_snan || b_snan;
    assign both_zero = (s1_a_q[30:0] == '0) && (s1_b_q[30:0] == '0);
    assign a_lt_b    = fp_less(s1_a_q, s1_b_q);
    assign a_eq_b    = (s1_a_q == s1_b_q) || both_zero;  // +0 equals -0

    always_comb begin
        result_d = s1_a_q;
        status_d = '0;

        case (s1_op_q)
            fpu_wrap_pkg::SGNJ: begin
                case (s1_sub_q)
                    fpu_wrap_pkg::SGNJ_PLAIN: result_d = {s1_b_q[31], s1_a_q[30:0]};
                    fpu_wrap_pkg::SGNJ_NEG:   result_d = {!s1_b_q[31], s1_a_q[30:0]};
                    fpu_wrap_pkg::SGNJ_XOR:   result_d = {s1_a_q[31] ^ s1_b_q[31], s1_a_q[30:0]};
                    default:                  result_d = s1_a_q;  // PASS, moves
                endcase
            end
            fpu_wrap_pkg::MINMAX: begin
                status_d[fpu_wrap_pkg::NV_BIT] = any_snan;
                if (a_nan && b_nan) begin
                    result_d = fpu_wrap_pkg::CANONICAL_NAN;
                end else if (a_nan) begin
                    result_d = s1_b_q;                  // The other operand wins
                end else if (b_nan) begin
                    result_d = s1_a_q;
                end else begin
                    case (s1_sub_q)
                        fpu_wrap_pkg::MM_MIN: result_d = a_lt_b ? s1_a_q : s1_b_q;
                        fpu_wrap_pkg::MM_MAX: result_d = a_lt_b ? s1_b_q : s1_a_q;
                        default:              result_d = fpu_wrap_pkg::CANONICAL_NAN;
                    endcase
                end
            end
            fpu_wrap_pkg::CMP: begin
                result_d = '0;
                case (s1_sub_q)
                    fpu_wrap_pkg::CMP_LE: begin
                        result_d[0]                    = !any_nan && (a_lt_b || a_eq_b);
                        status_d[fpu_wrap_pkg::NV_BIT] = any_nan;   // Signalling compare
                    end
                    fpu_wrap_pkg::CMP_LT: begin
                        result_d[0]                    = !any_nan && a_lt_b && !both_zero;
                        status_d[fpu_wrap_pkg::NV_BIT] = any_nan;
                    end
                    fpu_wrap_pkg::CMP_EQ: begin
                        result_d[0]                    = !any_nan && a_eq_b;
                        status_d[fpu_wrap_pkg::NV_BIT] = any_snan;  // Quiet compare
                    end
                    default: ;
                endcase
            end
            default: result_d = {22'b0, cls_a};         // CLASSIFY on operand a
        endcase
    end

    // ------------------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;                         // Everything in flight is lost
            s2_valid_q <= 1'b0;
        end else begin
            if (in_ready_o) s1_valid_q <= in_valid_i;
            if (s2_ready)   s2_valid_q <= s1_valid_q;
        end
    end

    // Payload only moves with its valid
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            s1_op_q  <= fp_op_i;
            s1_sub_q <= sub_op_i;
            s1_a_q   <= operand_a_i;
            s1_b_q   <= operand_b_i;
            s1_tag_q <= tag_i;
        end
        if (s1_valid_q && s2_ready) begin
            s2_result_q <= result_d;
            s2_status_q <= status_d;
            s2_tag_q    <= s1_tag_q;
        end
    end

    assign out_valid_o = s2_valid_q;
    assign result_o    = s2_result_q;
    assign status_o    = s2_status_q;
    assign tag_o       = s2_tag_q;

endmodule

`default_nettype wire

/* hw/fp_op_decoder.sv */
// Purely combinational; operators outside fu_op_e fall back to sign injection on the masked rm
`timescale 1ns/1ps
`default_nettype none

module fp_op_decoder (
    input  fpu_wrap_pkg::fu_op_e  fu_op_i,
    input  fpu_wrap_pkg::sub_op_t fpu_rm_i,
    output fpu_wrap_pkg::fp_op_e  fp_op_o,
    output fpu_wrap_pkg::sub_op_t sub_op_o
);

    fpu_wrap_pkg::sub_op_t rm_masked;  // rm with the MSB cleared

    // MSB of rm carried the alternate-half format, never used here
    assign rm_masked = {1'b0, fpu_rm_i[1:0]};

    // ------------------------------------------------------------------------
    // Operator translation
    // ------------------------------------------------------------------------
    always_comb begin
        // Sign injection unless told otherwise
        fp_op_o  = fpu_wrap_pkg::SGNJ;
        sub_op_o = rm_masked;

        case (fu_op_i)
            fpu_wrap_pkg::FSGNJ: begin
                fp_op_o  = fpu_wrap_pkg::SGNJ;
                sub_op_o = rm_masked;   // PLAIN, NEG or XOR
            end
            fpu_wrap_pkg::FMIN_MAX: begin
                fp_op_o  = fpu_wrap_pkg::MINMAX;
                sub_op_o = rm_masked;   // MIN or MAX
            end
            fpu_wrap_pkg::FCMP: begin
                fp_op_o  = fpu_wrap_pkg::CMP;
                sub_op_o = rm_masked;   // LE, LT or EQ
            end
            fpu_wrap_pkg::FCLASS: begin
                fp_op_o  = fpu_wrap_pkg::CLASSIFY;
                sub_op_o = '0;          // Classify has no sub-operation
            end
            // Moves need no recoding, pass operand a straight through
            fpu_wrap_pkg::FMV_F2X,
            fpu_wrap_pkg::FMV_X2F: begin
                fp_op_o  = fpu_wrap_pkg::SGNJ;
                sub_op_o = fpu_wrap_pkg::SGNJ_PASS;
            end
            default: ;                  // Keep the defaults
        endcase
    end

endmodule

`default_nettype wire

/* hw/fpu_wrap.sv */
// FP32 non-computational ops only; fpu_ready_o follows unit readiness in the same cycle
`timescale 1ns/1ps
`default_nettype none

module fpu_wrap (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      fpu_valid_i,
    input  fpu_wrap_pkg::fu_op_e      fu_op_i,
    input  fpu_wrap_pkg::fp_word_t    operand_a_i,
    input  fpu_wrap_pkg::fp_word_t    operand_b_i,
    input  fpu_wrap_pkg::sub_op_t     fpu_rm_i,
    input  fpu_wrap_pkg::trans_id_t   trans_id_i,
    input  logic                      fpu_ready_i,
    output logic                      fpu_ready_o,
    output logic                      fpu_valid_o,
    output fpu_wrap_pkg::fp_word_t    result_o,
    output fpu_wrap_pkg::trans_id_t   fpu_trans_id_o,
    output fpu_wrap_pkg::fp_status_t  fpu_status_o
);

    fpu_wrap_pkg::fp_op_e      dec_op, unit_op;
    fpu_wrap_pkg::sub_op_t     dec_sub, unit_sub;
    fpu_wrap_pkg::fp_word_t    unit_a, unit_b;
    fpu_wrap_pkg::trans_id_t   unit_tag;
    logic                      unit_valid, unit_ready;

    fp_op_decoder i_decoder (
        .fu_op_i  (fu_op_i),
        .fpu_rm_i (fpu_rm_i),
        .fp_op_o  (dec_op),
        .sub_op_o (dec_sub)
    );

    issue_hold_buffer i_hold (
        .clk_i, .rst_ni, .flush_i,
        .valid_i      (fpu_valid_i),
        .fp_op_i      (dec_op),
        .sub_op_i     (dec_sub),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .tag_i        (trans_id_i),
        .unit_ready_i (unit_ready),
        .ready_o      (fpu_ready_o),
        .unit_valid_o (unit_valid),
        .fp_op_o      (unit_op),
        .sub_op_o     (unit_sub),
        .operand_a_o  (unit_a),
        .operand_b_o  (unit_b),
        .tag_o        (unit_tag)
    );

    fp_noncomp_unit i_unit (
        .clk_i, .rst_ni, .flush_i,
        .in_valid_i  (unit_valid),
        .fp_op_i     (unit_op),
        .sub_op_i    (unit_sub),
        .operand_a_i (unit_a),
        .operand_b_i (unit_b),
        .tag_i       (unit_tag),
        .in_ready_o  (unit_ready),
        .out_valid_o (fpu_valid_o),
        .result_o    (result_o),
        .status_o    (fpu_status_o),
        .tag_o       (fpu_trans_id_o),
        .out_ready_i (fpu_ready_i)     // Real back-pressure from writeback
    );

endmodule

`default_nettype wire

/* hw/fpu_wrap_pkg.sv */
// Scalar FP32 only; the 3-bit rm field doubles as sub-operation, NV is the only flag ever raised
`default_nettype none

package fpu_wrap_pkg;

    // ------------------------------------------------------------------------
    // Widths and vector types
    // ------------------------------------------------------------------------
    localparam int FLEN          = 32;  // Operand and result width
    localparam int TRANS_ID_BITS = 3;   // Transaction tag width

    typedef logic [FLEN-1:0]          fp_word_t;   // One FP32 word
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;  // Scoreboard tag
    typedef logic [2:0]               sub_op_t;    // rm field reused as selector
    typedef logic [4:0]               fp_status_t; // NV DZ OF UF NX

    // ------------------------------------------------------------------------
    // Operation encodings
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } fu_op_e;                                     // Issue-side operator

    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } fp_op_e;                                     // Unit operation

    typedef enum logic {
        READY = 1'b0,
        STALL = 1'b1
    } hold_state_e;                                // Protocol-inversion FSM

    // Sign injection sub-operations
    localparam sub_op_t SGNJ_PLAIN = 3'b000;
    localparam sub_op_t SGNJ_NEG   = 3'b001;
    localparam sub_op_t SGNJ_XOR   = 3'b010;
    localparam sub_op_t SGNJ_PASS  = 3'b011;  // Used for both moves

    // Min/max and compare sub-operations
    localparam sub_op_t MM_MIN = 3'b000;
    localparam sub_op_t MM_MAX = 3'b001;
    localparam sub_op_t CMP_LE = 3'b000;
    localparam sub_op_t CMP_LT = 3'b001;
    localparam sub_op_t CMP_EQ = 3'b010;

    localparam fp_word_t CANONICAL_NAN = 32'h7FC0_0000;
    localparam int       NV_BIT        = 4;   // Invalid operation flag

    // Classify mask bit positions
    localparam int CLASS_NEG_INF  = 0;
    localparam int CLASS_NEG_NORM = 1;
    localparam int CLASS_NEG_SUB  = 2;
    localparam int CLASS_NEG_ZERO = 3;
    localparam int CLASS_POS_ZERO = 4;
    localparam int CLASS_POS_SUB  = 5;
    localparam int CLASS_POS_NORM = 6;
    localparam int CLASS_POS_INF  = 7;
    localparam int CLASS_SNAN     = 8;
    localparam int CLASS_QNAN     = 9;

endpackage

`default_nettype wire

/* hw/issue_hold_buffer.sv */
// Issue may not drop valid once raised; ready_o depends combinationally on unit_ready_i
`timescale 1ns/1ps
`default_nettype none

module issue_hold_buffer (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      valid_i,
    input  fpu_wrap_pkg::fp_op_e      fp_op_i,
    input  fpu_wrap_pkg::sub_op_t     sub_op_i,
    input  fpu_wrap_pkg::fp_word_t    operand_a_i,
    input  fpu_wrap_pkg::fp_word_t    operand_b_i,
    input  fpu_wrap_pkg::trans_id_t   tag_i,
    input  logic                      unit_ready_i,
    output logic                      ready_o,
    output logic                      unit_valid_o,
    output fpu_wrap_pkg::fp_op_e      fp_op_o,
    output fpu_wrap_pkg::sub_op_t     sub_op_o,
    output fpu_wrap_pkg::fp_word_t    operand_a_o,
    output fpu_wrap_pkg::fp_word_t    operand_b_o,
    output fpu_wrap_pkg::trans_id_t   tag_o
);

    fpu_wrap_pkg::hold_state_e state_q, state_d;
    logic                      hold_inputs;    // Load the hold register
    logic                      use_hold;       // Drive the unit from the hold register

    fpu_wrap_pkg::fp_op_e      fp_op_q;
    fpu_wrap_pkg::sub_op_t     sub_op_q;
    fpu_wrap_pkg::fp_word_t    operand_a_q;
    fpu_wrap_pkg::fp_word_t    operand_b_q;
    fpu_wrap_pkg::trans_id_t   tag_q;

    // ------------------------------------------------------------------------
    // Protocol inversion FSM
    // ------------------------------------------------------------------------
    always_comb begin
        ready_o      = 1'b0;
        unit_valid_o = 1'b0;
        hold_inputs  = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        case (state_q)
            fpu_wrap_pkg::READY: begin
                ready_o      = 1'b1;       // Look ready to issue
                unit_valid_o = valid_i;    // Live request straight to the unit
                // Unit busy, park the request and stall issue
                if (valid_i && !unit_ready_i) begin
                    ready_o     = 1'b0;
                    hold_inputs = 1'b1;
                    state_d     = fpu_wrap_pkg::STALL;
                end
            end
            fpu_wrap_pkg::STALL: begin
                unit_valid_o = 1'b1;       // Held request pending
                use_hold     = 1'b1;
                if (unit_ready_i) begin
                    ready_o = 1'b1;        // Token back to issue
                    state_d = fpu_wrap_pkg::READY;
                end
            end
            default: state_d = fpu_wrap_pkg::READY;
        endcase

        if (flush_i) begin
            state_d = fpu_wrap_pkg::READY; // Drop whatever is held
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= fpu_wrap_pkg::READY;
            fp_op_q     <= fpu_wrap_pkg::SGNJ;
            sub_op_q    <= '0;
            operand_a_q <= '0;
            operand_b_q <= '0;
            tag_q       <= '0;
        end else begin
            state_q <= state_d;
            if (hold_inputs) begin
                fp_op_q     <= fp_op_i;
                sub_op_q    <= sub_op_i;
                operand_a_q <= operand_a_i;
                operand_b_q <= operand_b_i;
                tag_q       <= tag_i;
            end
        end
    end

    // Held fields while stalled, live fields otherwise
    assign fp_op_o     = use_hold ? fp_op_q     : fp_op_i;
    assign sub_op_o    = use_hold ? sub_op_q    : sub_op_i;
    assign operand_a_o = use_hold ? operand_a_q : operand_a_i;
    assign operand_b_o = use_hold ? operand_b_q : operand_b_i;
    assign tag_o       = use_hold ? tag_q       : tag_i;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the fpu_wrap testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f verilog.f \
    --top-module tb_fpu_wrap -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "^Finished with no errors$" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

/* verification/fp_ref_model.svh */
// Expected FP32 results taken from the issue operator and rm field; only rm low bits are decoded
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Monotonic key, unsigned compare gives numeric order with -0 below +0
function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
endfunction

function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];                 // Quiet bit clear
endfunction

// One-hot class, bit 0 is -inf up to bit 9 quiet NaN
function automatic logic [9:0] expected_class(input logic [31:0] x);
    logic [9:0] m;
    m = '0;
    if (is_nan(x))                    m[x[22] ? 9 : 8] = 1'b1;
    else if (x[30:23] == 8'hFF)       m[x[31] ? 0 : 7] = 1'b1;   // Infinity
    else if (x[30:0] == 31'd0)        m[x[31] ? 3 : 4] = 1'b1;   // Zero
    else if (x[30:23] == 8'h00)       m[x[31] ? 2 : 5] = 1'b1;   // Subnormal
    else                              m[x[31] ? 1 : 6] = 1'b1;   // Normal
    return m;
endfunction

function automatic void model_op(input logic [2:0] op, input logic [2:0] rm,
                                 input logic [31:0] a, input logic [31:0] b,
                                 output logic [31:0] res, output logic [4:0] st);
    logic lt;
    logic eq;
    logic any_nan;
    lt      = order_key(a) < order_key(b);
    eq      = (a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0));
    any_nan = is_nan(a) || is_nan(b);
    res     = a;
    st      = '0;
    case (op)
        fpu_wrap_pkg::FSGNJ: begin
            case (rm[1:0])
                2'd0:    res = {b[31], a[30:0]};
                2'd1:    res = {~b[31], a[30:0]};
                2'd2:    res = {a[31] ^ b[31], a[30:0]};
                default: res = a;                          // Pass
            endcase
        end
        fpu_wrap_pkg::FMIN_MAX: begin
            st[4] = is_snan(a) || is_snan(b);
            if (is_nan(a) && is_nan(b)) res = 32'h7FC0_0000;
            else if (is_nan(a))         res = b;
            else if (is_nan(b))         res = a;
            else if (rm[1:0] == 2'd0)   res = lt ? a : b;      // Min
            else                        res = lt ? b : a;      // Max
        end
        fpu_wrap_pkg::FCMP: begin
            res = '0;
            case (rm[1:0])
                2'd0: begin res[0] = !any_nan && (lt || eq); st[4] = any_nan; end
                2'd1: begin res[0] = !any_nan && lt && !eq; st[4] = any_nan; end
                default: begin
                    res[0] = !any_nan && eq;
                    st[4]  = is_snan(a) || is_snan(b);     // Quiet equality
                end
            endcase
        end
        fpu_wrap_pkg::FCLASS: res = {22'd0, expected_class(a)};
        default: res = a;                                  // Both moves
    endcase
endfunction

`endif

/* verification/tb_fpu_wrap.sv */
// Self-checking testbench for fpu_wrap; issue side holds its request until fpu_ready_o, ops use legal rm
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_wrap;

    `include "fp_ref_model.svh"

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     flush_i;
    logic                     fpu_valid_i;
    fpu_wrap_pkg::fu_op_e     fu_op_i;
    fpu_wrap_pkg::fp_word_t   operand_a_i, operand_b_i;
    fpu_wrap_pkg::sub_op_t    fpu_rm_i;
    fpu_wrap_pkg::trans_id_t  trans_id_i;
    logic                     fpu_ready_i;
    logic                     fpu_ready_o, fpu_valid_o;
    fpu_wrap_pkg::fp_word_t   result_o;
    fpu_wrap_pkg::trans_id_t  fpu_trans_id_o;
    fpu_wrap_pkg::fp_status_t fpu_status_o;

    // Scoreboard, one entry per upstream transfer
    logic [31:0] exp_res_q[$];
    logic [4:0]  exp_st_q[$];
    logic [2:0]  exp_tag_q[$];
    int          exp_cyc_q[$];
    logic [31:0] m_res;
    logic [4:0]  m_st;

    int errors = 0, checks = 0, tests = 0, out_count = 0, cycle_cnt = 0;
    int ds_mode = 0;                // 0 ready high, 1 random, 2 ready low
    logic check_latency = 1'b0;
    fpu_wrap_pkg::trans_id_t next_tag = '0;

    fpu_wrap_pkg::fp_word_t specials [0:11] = '{
        32'hFF80_0000, 32'hBF80_0000, 32'h8000_0005, 32'h8000_0000,
        32'h0000_0000, 32'h0000_0003, 32'h3F80_0000, 32'h7F80_0000,
        32'h7F80_0001, 32'h7FC0_0000, 32'hFFC1_2345, 32'h4120_0000
    };

    fpu_wrap UUT (.*);

    always #10 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Downstream ready and monitor
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        #2;
        if (ds_mode == 0)      fpu_ready_i = 1'b1;
        else if (ds_mode == 1) fpu_ready_i = 1'($urandom % 2);
        else                   fpu_ready_i = 1'b0;
    end

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (fpu_valid_o && fpu_ready_i) begin
                checks++;
                out_count++;
                assert (exp_res_q.size() > 0) else begin
                    errors++;
                    $display("CHECK FAILED @%0t: unexpected output, tag %0d", $time,
                             fpu_trans_id_o);
                end
                if (exp_res_q.size() > 0) begin
                    assert (result_o === exp_res_q[0] && fpu_status_o === exp_st_q[0]) else begin
                        errors++;
                        $display("CHECK FAILED @%0t: tag %0d got %h/%b expected %h/%b", $time,
                                 fpu_trans_id_o, result_o, fpu_status_o, exp_res_q[0],
                                 exp_st_q[0]);
                    end
                    assert (fpu_trans_id_o === exp_tag_q[0]) else begin
                        errors++;
                        $display("CHECK FAILED @%0t: tag %0d expected %0d", $time,
                                 fpu_trans_id_o, exp_tag_q[0]);
                    end
                    if (check_latency) begin
                        assert (cycle_cnt - exp_cyc_q[0] == 2) else begin
                            errors++;
                            $display("CHECK FAILED @%0t: latency %0d expected 2", $time,
                                     cycle_cnt - exp_cyc_q[0]);
                        end
                    end
                    void'(exp_res_q.pop_front());
                    void'(exp_st_q.pop_front());
                    void'(exp_tag_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                end
            end
            // Upstream transfer, compute what must come out
            if (fpu_valid_i && fpu_ready_o) begin
                model_op(fu_op_i, fpu_rm_i, operand_a_i, operand_b_i, m_res, m_st);
                exp_res_q.push_back(m_res);
                exp_st_q.push_back(m_st);
                exp_tag_q.push_back(trans_id_i);
                exp_cyc_q.push_back(cycle_cnt);
            end
            if (flush_i) begin                      // All in flight is lost
                exp_res_q.delete();
                exp_st_q.delete();
                exp_tag_q.delete();
                exp_cyc_q.delete();
            end
        end
        cycle_cnt++;
    end

    // Output frozen while downstream stalls
    a_hold_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fpu_valid_o && !fpu_ready_i && !flush_i) |=>
        (fpu_valid_o && $stable(result_o) && $stable(fpu_trans_id_o) && $stable(fpu_status_o)))
        else begin
            errors++;
            $display("CHECK FAILED @%0t: output changed while stalled", $time);
        end

    a_flush_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> fpu_ready_o)
        else begin
            errors++;
            $display("CHECK FAILED @%0t: fpu_ready_o low after flush", $time);
        end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    task automatic issue_op(input logic [2:0] op, input logic [2:0] rm,
                            input logic [31:0] a, input logic [31:0] b);
        int   waited = 0;
        logic accepted = 1'b0;
        fu_op_i     = fpu_wrap_pkg::fu_op_e'(op);
        fpu_rm_i    = rm;
        operand_a_i = a;
        operand_b_i = b;
        trans_id_i  = next_tag;
        fpu_valid_i = 1'b1;
        while (!accepted) begin
            @(posedge clk_i);
            accepted = fpu_ready_o;
            waited++;
            if (!accepted && waited > 200) abort_run("Timeout: issue never accepted");
        end
        #2;
        fpu_valid_i = 1'b0;
        next_tag++;
    endtask

    task automatic wait_drain();
        int waited = 0;
        while (exp_res_q.size() != 0) begin
            step();
            waited++;
            if (waited > 1000) abort_run("Timeout: results never drained");
        end
    endtask

    function automatic logic [31:0] pick_operand();
        if ($urandom % 3 == 0) return specials[$urandom % 12];
        return $urandom;
    endfunction

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    initial begin
        int e0;
        int flushed_at;
        logic [2:0] op;
        logic [2:0] rm;
        void'($urandom(84));
        rst_ni = 1'b0;
        flush_i = 1'b0;
        fpu_valid_i = 1'b0;
        fu_op_i = fpu_wrap_pkg::FSGNJ;
        operand_a_i = '0;
        operand_b_i = '0;
        fpu_rm_i = '0;
        trans_id_i = '0;
        fpu_ready_i = 1'b1;
        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        step();
        assert (fpu_ready_o && !fpu_valid_o) else begin
            errors++;
            $display("CHECK FAILED @%0t: wrong handshake state after reset", $time);
        end

        e0 = errors;                                 // Sign injection and moves
        for (int k = 0; k < 5; k++) begin
            for (int i = 0; i < 24; i++) begin
                op = (k < 3) ? 3'd0 : 3'(k + 1);
                rm = (k < 3) ? 3'(k) | {1'($urandom % 2), 2'b00} : 3'($urandom % 8);
                issue_op(op, rm, pick_operand(), pick_operand());
            end
        end
        wait_drain();
        end_test("sign injection and moves", e0);

        e0 = errors;                                 // All special pairs
        for (int r = 0; r < 2; r++)
            for (int i = 0; i < 12; i++)
                for (int j = 0; j < 12; j++)
                    issue_op(3'd1, 3'(r), specials[i], specials[j]);
        wait_drain();
        end_test("min/max", e0);

        e0 = errors;
        for (int r = 0; r < 3; r++)
            for (int i = 0; i < 12; i++)
                for (int j = 0; j < 12; j++)
                    issue_op(3'd2, 3'(r), specials[i], specials[j]);
        for (int i = 0; i < 12; i++) issue_op(3'd3, 3'($urandom % 8), specials[i], 32'd0);
        wait_drain();
        end_test("compare and classify", e0);

        e0 = errors;                                 // Single ops, ready held high
        check_latency = 1'b1;
        for (int i = 0; i < 12; i++) begin
            issue_op(3'($urandom % 6), 3'($urandom % 2), pick_operand(), pick_operand());
            wait_drain();
            step();
        end
        check_latency = 1'b0;
        end_test("latency", e0);

        e0 = errors;
        ds_mode = 1;
        for (int i = 0; i < 200; i++) begin
            op = 3'($urandom % 6);
            rm = (op == 3'd0) ? 3'($urandom % 4) : 3'($urandom % 2);
            issue_op(op, rm, pick_operand(), pick_operand());
            repeat ($urandom % 4) step();
        end
        ds_mode = 0;
        wait_drain();
        end_test("back-pressure", e0);

        e0 = errors;                                 // Fill both stages, then stall
        ds_mode = 2;
        step();
        step();
        issue_op(3'd0, 3'd0, pick_operand(), pick_operand());
        issue_op(3'd1, 3'd1, pick_operand(), pick_operand());
        fu_op_i     = fpu_wrap_pkg::FCLASS;
        operand_a_i = pick_operand();
        trans_id_i  = next_tag;
        fpu_valid_i = 1'b1;
        step();
        step();
        flush_i = 1'b1;
        step();
        flush_i     = 1'b0;
        fpu_valid_i = 1'b0;
        next_tag++;
        flushed_at  = out_count;
        assert (fpu_ready_o) else begin
            errors++;
            $display("CHECK FAILED @%0t: not ready after flush", $time);
        end
        ds_mode = 0;
        step();
        step();
        issue_op(3'd2, 3'd2, 32'h3F80_0000, 32'h3F80_0000);
        wait_drain();
        repeat (3) step();
        assert (out_count == flushed_at + 1) else begin
            errors++;
            $display("CHECK FAILED @%0t: %0d outputs after flush, expected 1", $time,
                     out_count - flushed_at);
        end
        end_test("flush", e0);

        $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verification
hw/fpu_wrap_pkg.sv
hw/fp_op_decoder.sv
hw/issue_hold_buffer.sv
hw/fp_noncomp_unit.sv
hw/fpu_wrap.sv
verification/tb_fpu_wrap.sv
